// ==== hw/trs_video_pkg.sv ====
package trs_video_pkg;

   localparam int CELL_W = 8;                     // pixels per character cell

   typedef logic [2:0]        cell_phase_t;       // pixel within the cell
   typedef logic [6:0]        char_col_t;         // 0-99, blanking included
   typedef logic [4:0]        char_row_t;
   typedef logic [4:0]        scan_line_t;        // scan line inside a char row
   typedef logic [7:0]        char_code_t;
   typedef logic [10:0]       dsp_addr_t;
   typedef logic [10:0]       glyph_addr_t;       // {code[6:0], glyph row}
   typedef logic [11:0]       host_addr_t;        // bit 11 picks the glyph ram
   typedef logic [CELL_W-1:0] pixel_row_t;

   // horizontal, in cells
   localparam char_col_t   H_TOTAL_COLS    = 7'd100;
   localparam char_col_t   ACTIVE_COLS     = 7'd80;
   localparam char_col_t   HSYNC_START_COL = 7'd82;
   localparam char_col_t   HSYNC_END_COL   = 7'd94;
   localparam cell_phase_t HSYNC_PHASE     = 3'd2;  // both sync edges sit here

   // 64x16 window, centred in the 80x20 grid
   localparam char_col_t   TEXT64_COLS     = 7'd64;
   localparam char_row_t   TEXT64_ROWS     = 5'd16;
   localparam char_col_t   TEXT64_COL_OFS  = 7'd8;
   localparam char_row_t   TEXT64_ROW_OFS  = 5'd2;

   // vertical
   localparam scan_line_t  LINES_64        = 5'd24;  // 12 glyph rows, doubled
   localparam scan_line_t  LINES_80        = 5'd20;  // 10 glyph rows, doubled
   localparam char_row_t   ROWS_ACTIVE_64  = 5'd20;
   localparam char_row_t   ROWS_ACTIVE_80  = 5'd24;
   localparam char_row_t   LAST_ROW_64     = 5'd21;
   localparam scan_line_t  LAST_SCAN_64    = 5'd20;  // 21*24 + 21 = 525 lines
   localparam char_row_t   LAST_ROW_80     = 5'd26;
   localparam scan_line_t  LAST_SCAN_80    = 5'd4;   // 26*20 + 5 = 525 lines
   localparam scan_line_t  VSYNC_START_SCAN = 5'd9;  // first row below the active area
   localparam scan_line_t  VSYNC_END_SCAN   = 5'd11;

   localparam logic [1:0]  BLOCK_PREFIX    = 2'b10;  // codes 0x80-0xbf

   // raster position, travels down the pixel pipeline
   typedef struct packed {
      cell_phase_t phase;
      char_col_t   col;
      char_row_t   row;
      scan_line_t  scan;
      logic        vga_act;    // inside 640x480
      logic        text_act;   // inside the text window of the mode
      logic        mode_80;    // frame's latched mode
   } scan_pos_t;

   // one host access, shared by both rams
   typedef struct packed {
      logic       dsp_en;
      logic       glyph_en;
      logic       we;
      dsp_addr_t  addr;
      char_code_t wdata;
   } host_access_t;

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      RESPOND,
      RELEASE
   } host_state_e;

endpackage

// ==== hw/video_timing.sv ====
`timescale 1ns/100ps

module video_timing (
   input  logic                     vga_clk,
   input  logic                     rst_n,
   input  logic                     mode_80col,
   output trs_video_pkg::scan_pos_t pos,
   output logic                     h_sync,
   output logic                     v_sync
);

   trs_video_pkg::cell_phase_t phase;
   trs_video_pkg::char_col_t   col;
   trs_video_pkg::char_row_t   row;
   trs_video_pkg::scan_line_t  scan;
   logic                       mode_80;          // latched copy of mode_80col

   trs_video_pkg::scan_line_t  row_last_scan;
   trs_video_pkg::char_row_t   frame_last_row;
   trs_video_pkg::scan_line_t  frame_last_scan;
   trs_video_pkg::char_row_t   rows_active;
   trs_video_pkg::char_col_t   col64;
   trs_video_pkg::char_row_t   row64;
   logic                       cell_end;
   logic                       line_end;
   logic                       frame_end;
   logic                       vga_act;
   logic                       in_text64;

   always_comb
   begin
      // wrap limits follow the latched mode
      row_last_scan   = mode_80 ? trs_video_pkg::LINES_80 - 5'd1 :
                                  trs_video_pkg::LINES_64 - 5'd1;
      frame_last_row  = mode_80 ? trs_video_pkg::LAST_ROW_80  : trs_video_pkg::LAST_ROW_64;
      frame_last_scan = mode_80 ? trs_video_pkg::LAST_SCAN_80 : trs_video_pkg::LAST_SCAN_64;
      rows_active     = mode_80 ? trs_video_pkg::ROWS_ACTIVE_80 : trs_video_pkg::ROWS_ACTIVE_64;

      cell_end  = phase == trs_video_pkg::cell_phase_t'(trs_video_pkg::CELL_W - 1);
      line_end  = cell_end && (col == trs_video_pkg::H_TOTAL_COLS - 7'd1);
      frame_end = line_end && (row == frame_last_row) && (scan == frame_last_scan);

      // offsets wrap below zero, so left/top border fails the compare
      col64     = col - trs_video_pkg::TEXT64_COL_OFS;
      row64     = row - trs_video_pkg::TEXT64_ROW_OFS;
      in_text64 = (col64 < trs_video_pkg::TEXT64_COLS) && (row64 < trs_video_pkg::TEXT64_ROWS);
      vga_act   = (col < trs_video_pkg::ACTIVE_COLS) && (row < rows_active);

      pos.phase    = phase;
      pos.col      = col;
      pos.row      = row;
      pos.scan     = scan;
      pos.vga_act  = vga_act;
      pos.text_act = vga_act && (mode_80 || in_text64);   // 80x24 fills the screen
      pos.mode_80  = mode_80;
   end

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         phase   <= '0;
         col     <= '0;
         row     <= '0;
         scan    <= '0;
         mode_80 <= mode_80col;           // first frame after reset
      end
      else
      begin
         phase <= cell_end ? '0 : phase + 3'd1;
         if (line_end)
         begin
            col <= '0;
            if (frame_end)
            begin
               row     <= '0;
               scan    <= '0;
               mode_80 <= mode_80col;     // mode only changes at frame start
            end
            else if (scan == row_last_scan)
            begin
               scan <= '0;
               row  <= row + 5'd1;
            end
            else
               scan <= scan + 5'd1;
         end
         else if (cell_end)
            col <= col + 7'd1;
      end
   end

   // registered syncs, rise one cycle after the match
   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         h_sync <= 1'b0;
         v_sync <= 1'b0;
      end
      else
      begin
         if (col == trs_video_pkg::HSYNC_START_COL && phase == trs_video_pkg::HSYNC_PHASE)
            h_sync <= 1'b1;                               // x = 659
         else if (col == trs_video_pkg::HSYNC_END_COL && phase == trs_video_pkg::HSYNC_PHASE)
            h_sync <= 1'b0;                               // low again at x = 755

         // line 489 to 491 in both modes
         if (row == rows_active && scan == trs_video_pkg::VSYNC_START_SCAN)
            v_sync <= 1'b1;
         else if (row == rows_active && scan == trs_video_pkg::VSYNC_END_SCAN)
            v_sync <= 1'b0;
      end
   end

endmodule

// ==== hw/host_bus_port.sv ====
`timescale 1ns/100ps

module host_bus_port (
   input  logic                        vga_clk,
   input  logic                        rst_n,
   input  logic                        host_req,
   input  logic                        host_we,
   input  trs_video_pkg::host_addr_t   host_addr,
   input  trs_video_pkg::char_code_t   host_wdata,
   output trs_video_pkg::host_access_t acc,
   input  trs_video_pkg::char_code_t   dsp_rdata,
   input  trs_video_pkg::char_code_t   glyph_rdata,
   output logic                        host_ack,
   output trs_video_pkg::char_code_t   host_rdata
);

   trs_video_pkg::host_state_e state;
   logic                       dsp_en_q;      // one-cycle strobes
   logic                       glyph_en_q;
   logic                       we_q;
   trs_video_pkg::dsp_addr_t   addr_q;
   trs_video_pkg::char_code_t  wdata_q;
   logic                       sel_glyph;     // target of the transfer in flight

   assign acc = '{dsp_en: dsp_en_q, glyph_en: glyph_en_q, we: we_q,
                  addr: addr_q, wdata: wdata_q};

   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         state      <= trs_video_pkg::IDLE;
         dsp_en_q   <= 1'b0;
         glyph_en_q <= 1'b0;
         host_ack   <= 1'b0;
      end
      else
      begin
         dsp_en_q   <= 1'b0;
         glyph_en_q <= 1'b0;
         case (state)
            trs_video_pkg::IDLE:
               if (host_req)                       // ack is low here, so req counts
               begin
                  dsp_en_q   <= !host_addr[11];
                  glyph_en_q <= host_addr[11];
                  state      <= trs_video_pkg::ACCESS;
               end
            trs_video_pkg::ACCESS:
               state <= trs_video_pkg::RESPOND;    // ram sees the strobe this cycle
            trs_video_pkg::RESPOND:
            begin
               host_ack <= 1'b1;                   // rdata registered alongside
               state    <= trs_video_pkg::RELEASE;
            end
            trs_video_pkg::RELEASE:
               if (!host_req)
               begin
                  host_ack <= 1'b0;
                  state    <= trs_video_pkg::IDLE;
               end
            default:
               state <= trs_video_pkg::IDLE;
         endcase
      end
   end

   // transfer payload, captured with the request
   always_ff @(posedge vga_clk)
   begin
      if (state == trs_video_pkg::IDLE && host_req)
      begin
         we_q      <= host_we;
         addr_q    <= host_addr[10:0];
         wdata_q   <= host_wdata;
         sel_glyph <= host_addr[11];
      end
      if (state == trs_video_pkg::RESPOND)
         host_rdata <= sel_glyph ? glyph_rdata : dsp_rdata;   // byte read in ACCESS
   end

endmodule

// ==== hw/text_fetch.sv ====
`timescale 1ns/100ps

module text_fetch (
   input  logic                        vga_clk,
   input  trs_video_pkg::scan_pos_t    pos_in,
   input  trs_video_pkg::host_access_t acc,
   output trs_video_pkg::char_code_t   dsp_rdata,
   output trs_video_pkg::scan_pos_t    pos_out,
   output trs_video_pkg::char_code_t   code
);

   localparam int DSP_DEPTH = 1 << $bits(trs_video_pkg::dsp_addr_t);

   trs_video_pkg::char_code_t dsp_mem [0:DSP_DEPTH-1];

   trs_video_pkg::char_col_t  col64;
   trs_video_pkg::char_row_t  row64;
   trs_video_pkg::dsp_addr_t  addr80;
   trs_video_pkg::dsp_addr_t  addr64;
   trs_video_pkg::dsp_addr_t  vid_addr;

   always_comb
   begin
      col64  = pos_in.col - trs_video_pkg::TEXT64_COL_OFS;
      row64  = pos_in.row - trs_video_pkg::TEXT64_ROW_OFS;
      // 80*row + col as two shifts
      addr80 = ({6'd0, pos_in.row} << 6) + ({6'd0, pos_in.row} << 4) + {4'd0, pos_in.col};
      addr64 = {1'b0, row64[3:0], col64[5:0]};   // 64 bytes per row, 1k used
      vid_addr = pos_in.mode_80 ? addr80 : addr64;
   end

   // host side, read-first
   always_ff @(posedge vga_clk)
   begin
      if (acc.dsp_en)
      begin
         if (acc.we)
            dsp_mem[acc.addr] <= acc.wdata;
         dsp_rdata <= dsp_mem[acc.addr];
      end
   end

   // video side, one read per cell at phase 0
   always_ff @(posedge vga_clk)
   begin
      if (pos_in.phase == 3'd0 && pos_in.text_act)
         code <= dsp_mem[vid_addr];      // holds until next cell's read
      pos_out <= pos_in;                 // one cycle behind, lines up with code
   end

endmodule

// ==== hw/glyph_render.sv ====
`timescale 1ns/100ps

module glyph_render (
   input  logic                        vga_clk,
   input  logic                        rst_n,
   input  logic                        inv_video,
   input  trs_video_pkg::scan_pos_t    pos,
   input  trs_video_pkg::char_code_t   code,
   input  trs_video_pkg::host_access_t acc,
   output trs_video_pkg::char_code_t   glyph_rdata,
   output logic                        pixel
);

   localparam int GLYPH_DEPTH = 1 << $bits(trs_video_pkg::glyph_addr_t);

   trs_video_pkg::char_code_t   glyph_mem [0:GLYPH_DEPTH-1];  // 128 chars x 16 rows

   trs_video_pkg::glyph_addr_t  vid_addr;
   logic [3:0]                  glyph_row;
   logic [11:0]                 blk_src;     // code above glyph row
   logic                        is_block;
   logic                        invert;
   trs_video_pkg::pixel_row_t   block_row;
   trs_video_pkg::pixel_row_t   text_row;
   trs_video_pkg::pixel_row_t   glyph_q;     // ram output
   trs_video_pkg::pixel_row_t   row_q;       // final row for this cell
   trs_video_pkg::pixel_row_t   shift_q;

   always_comb
   begin
      glyph_row = pos.scan[4:1];                        // scan lines doubled
      vid_addr  = {code[6:0], glyph_row};
      blk_src   = {code, glyph_row};
      is_block  = (code[7:6] == trs_video_pkg::BLOCK_PREFIX) && !inv_video;
      invert    = code[7] && inv_video;

      // 2x3 block, four glyph rows per group, left half from the lower bit
      case (glyph_row[3:2])
         2'd0:    block_row = {{4{blk_src[4]}}, {4{blk_src[5]}}};
         2'd1:    block_row = {{4{blk_src[6]}}, {4{blk_src[7]}}};
         2'd2:    block_row = {{4{blk_src[8]}}, {4{blk_src[9]}}};
         default: block_row = '0;                       // rows 12-15, unused
      endcase

      text_row = glyph_q ^ {trs_video_pkg::CELL_W{invert}};
   end

   // host side
   always_ff @(posedge vga_clk)
   begin
      if (acc.glyph_en)
      begin
         if (acc.we)
            glyph_mem[acc.addr] <= acc.wdata;
         glyph_rdata <= glyph_mem[acc.addr];
      end
   end

   // pos lags the raster by one, so phase n here is raster phase n+1
   always_ff @(posedge vga_clk)
   begin
      if (pos.phase == 3'd1 && pos.vga_act)
         glyph_q <= glyph_mem[vid_addr];        // raster phase 2
      if (pos.phase == 3'd2)                    // raster phase 3
      begin
         if (!pos.text_act)
            row_q <= '0;                        // border or blanking
         else if (is_block)
            row_q <= block_row;
         else
            row_q <= text_row;
      end
   end

   // load at end of raster phase 4, msb first
   always_ff @(posedge vga_clk)
   begin
      if (!rst_n)
         shift_q <= '0;
      else if (pos.phase == 3'd3)
         shift_q <= row_q;
      else
         shift_q <= {shift_q[trs_video_pkg::CELL_W-2:0], 1'b0};
   end

   assign pixel = shift_q[trs_video_pkg::CELL_W-1];

endmodule

// ==== hw/trs_video_top.sv ====
`timescale 1ns/100ps

module trs_video_top (
   input  logic                      vga_clk,
   input  logic                      rst_n,
   input  logic                      mode_80col,
   input  logic                      inv_video,
   input  logic                      host_req,
   input  logic                      host_we,
   input  trs_video_pkg::host_addr_t host_addr,
   input  trs_video_pkg::char_code_t host_wdata,
   output logic                      host_ack,
   output trs_video_pkg::char_code_t host_rdata,
   output logic                      pixel,
   output logic                      h_sync,
   output logic                      v_sync
);

   trs_video_pkg::scan_pos_t    pos_raw;      // straight from the counters
   trs_video_pkg::scan_pos_t    pos_dly;      // aligned with code
   trs_video_pkg::host_access_t acc;
   trs_video_pkg::char_code_t   code;
   trs_video_pkg::char_code_t   dsp_rdata;
   trs_video_pkg::char_code_t   glyph_rdata;

   video_timing i_video_timing (
      .vga_clk    (vga_clk),
      .rst_n      (rst_n),
      .mode_80col (mode_80col),
      .pos        (pos_raw),
      .h_sync     (h_sync),
      .v_sync     (v_sync)
   );

   host_bus_port i_host_bus_port (
      .vga_clk     (vga_clk),
      .rst_n       (rst_n),
      .host_req    (host_req),
      .host_we     (host_we),
      .host_addr   (host_addr),
      .host_wdata  (host_wdata),
      .acc         (acc),
      .dsp_rdata   (dsp_rdata),
      .glyph_rdata (glyph_rdata),
      .host_ack    (host_ack),
      .host_rdata  (host_rdata)
   );

   text_fetch i_text_fetch (
      .vga_clk   (vga_clk),
      .pos_in    (pos_raw),
      .acc       (acc),
      .dsp_rdata (dsp_rdata),
      .pos_out   (pos_dly),
      .code      (code)
   );

   glyph_render i_glyph_render (
      .vga_clk     (vga_clk),
      .rst_n       (rst_n),
      .inv_video   (inv_video),
      .pos         (pos_dly),
      .code        (code),
      .acc         (acc),
      .glyph_rdata (glyph_rdata),
      .pixel       (pixel)
   );

endmodule

// ==== tb/tb_trs_video_assert.sv ====
`timescale 1ns/100ps

module tb_trs_video_assert (
   input logic vga_clk,
   input logic rst_n,
   input logic host_req,
   input logic host_ack,
   input logic h_sync
);

   int   fail_cnt = 0;   // failed assertions so far
   int   hs_run;         // high cycles of the pulse in progress
   int   hs_width;       // length of the last finished pulse
   int   hs_since;       // cycles since the last rise
   int   hs_period;
   int   hs_rises;
   logic hs_prev;

   // measured on the falling edge, away from the dut updates
   always @(negedge vga_clk)
   begin
      if (!rst_n)
      begin
         hs_run   <= 0;
         hs_width <= 0;
         hs_since <= 0;
         hs_rises <= 0;
         hs_prev  <= 1'b0;
      end
      else
      begin
         hs_prev <= h_sync;
         hs_run  <= h_sync ? hs_run + 1 : 0;
         if (!h_sync && hs_prev)
            hs_width <= hs_run;                // pulse just ended
         if (h_sync && !hs_prev)
         begin
            hs_period <= hs_since + 1;
            hs_since  <= 0;
            hs_rises  <= hs_rises + 1;
         end
         else
            hs_since <= hs_since + 1;
      end
   end

   ack_after_req: assert property (@(posedge vga_clk) disable iff (!rst_n)
      $rose(host_ack) |-> $past(host_req))
      else begin fail_cnt++; $error("host_ack rose with no host_req pending"); end

   ack_release: assert property (@(posedge vga_clk) disable iff (!rst_n)
      $fell(host_ack) |-> !$past(host_req))
      else begin fail_cnt++; $error("host_ack fell before host_req was released"); end

   hsync_width: assert property (@(posedge vga_clk) disable iff (!rst_n)
      $fell(h_sync) |-> hs_width == 96)
      else begin fail_cnt++; $error("error hs_width: got %h expected %h", hs_width, 96); end

   hsync_period: assert property (@(posedge vga_clk) disable iff (!rst_n)
      $rose(h_sync) && hs_rises >= 2 |-> hs_period == 800)
      else begin fail_cnt++; $error("error hs_period: got %h expected %h", hs_period, 800); end

endmodule

bind trs_video_top tb_trs_video_assert i_tb_trs_video_assert (
   .vga_clk  (vga_clk),
   .rst_n    (rst_n),
   .host_req (host_req),
   .host_ack (host_ack),
   .h_sync   (h_sync)
);

// ==== tb/tb_trs_video.sv ====
`timescale 1ns/100ps

module tb_trs_video;

   localparam int TIMEOUT_CYCLES = 1400000;   // 3 frames plus the loading
   localparam int GLYPH_BYTES    = 2048;      // 128 chars x 16 rows
   localparam int TEXT_BYTES     = 1920;      // 80x24

   logic                      vga_clk = 1'b0;
   logic                      rst_n;
   logic                      mode_80col;
   logic                      inv_video;
   logic                      host_req;
   logic                      host_we;
   trs_video_pkg::host_addr_t host_addr;
   trs_video_pkg::char_code_t host_wdata;
   logic                      host_ack;
   trs_video_pkg::char_code_t host_rdata;
   logic                      pixel;
   logic                      h_sync;
   logic                      v_sync;

   logic [7:0]  dsp_shadow   [0:2047];       // what the rams should hold
   logic [7:0]  glyph_shadow [0:2047];
   logic [31:0] rnd = 32'hc34c_3648;
   int          pos_x = 0;                   // raster position of this cycle
   int          pos_line = 0;
   int          frame_cnt = 0;
   logic        frame_mode = 1'b0;
   logic        check_en = 1'b0;
   int          cycle_cnt = 0;
   int          host_err = 0;
   int          sync_err = 0;
   int          pix_err = 0;
   int          total_err;
   logic        exp_h;
   logic        exp_v;
   logic        exp_p;

   always #4 vga_clk = ~vga_clk;

   trs_video_top i_trs_video_top (
      .vga_clk    (vga_clk),
      .rst_n      (rst_n),
      .mode_80col (mode_80col),
      .inv_video  (inv_video),
      .host_req   (host_req),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_ack   (host_ack),
      .host_rdata (host_rdata),
      .pixel      (pixel),
      .h_sync     (h_sync),
      .v_sync     (v_sync)
   );

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // pixel seen at (line, x) from the display rules
   function automatic logic expected_pixel(input int line, input int x, input logic m80,
                                           input logic inv);
      int         xi;
      int         c;
      int         b;
      int         lpr;
      int         row;
      int         scan;
      int         addr;
      int         grp;
      logic [7:0] code;
      logic [7:0] bits;
      if (x < 5)
         return 1'b0;                   // tail of cell 99, always blank
      xi   = x - 5;
      c    = xi / 8;
      b    = 7 - xi % 8;                // msb goes out first
      lpr  = m80 ? 20 : 24;
      row  = line / lpr;
      scan = line % lpr;
      if (c >= 80 || row >= (m80 ? 24 : 20))
         return 1'b0;
      if (m80)
         addr = row * 80 + c;
      else if (c < 8 || c >= 72 || row < 2 || row >= 18)
         return 1'b0;                   // border around the 64x16 window
      else
         addr = (row - 2) * 64 + (c - 8);
      code = dsp_shadow[11'(addr)];
      if (code[7:6] == 2'b10 && !inv)
      begin
         grp = scan / 8;                // 4 glyph rows, doubled
         if (grp > 2)
            return 1'b0;
         return (b >= 4) ? code[3'(2 * grp)] : code[3'(2 * grp + 1)];
      end
      bits = glyph_shadow[{code[6:0], 4'(scan / 2)}];
      if (code[7] && inv)
         bits = ~bits;
      return bits[3'(b)];
   endfunction

   // full req/ack cycle, called just after a rising edge
   task automatic transfer(input logic we, input trs_video_pkg::host_addr_t addr,
                           input logic [7:0] wdata, output logic [7:0] rdata);
      host_we    = we;
      host_addr  = addr;
      host_wdata = wdata;
      host_req   = 1'b1;
      while (!host_ack)
      begin
         @(posedge vga_clk);
         #1;
      end
      rdata    = host_rdata;
      host_req = 1'b0;
      while (host_ack)                  // port must see req low first
      begin
         @(posedge vga_clk);
         #1;
      end
   endtask

   task automatic write_byte(input trs_video_pkg::host_addr_t addr, input logic [7:0] data);
      logic [7:0] unused;
      transfer(1'b1, addr, data, unused);
      if (addr[11])
         glyph_shadow[addr[10:0]] = data;
      else
         dsp_shadow[addr[10:0]] = data;
   endtask

   task automatic read_check(input trs_video_pkg::host_addr_t addr);
      logic [7:0] got;
      logic [7:0] want;
      transfer(1'b0, addr, 8'h00, got);
      want = addr[11] ? glyph_shadow[addr[10:0]] : dsp_shadow[addr[10:0]];
      assert (got === want)
      else
      begin
         host_err++;
         $display("error host_rdata addr %h: got %h expected %h", addr, got, want);
      end
   endtask

   task automatic wait_line(input int frame, input int line);
      while (!(frame_cnt == frame && pos_line == line && pos_x == 0))
      begin
         @(posedge vga_clk);
         #1;
      end
   endtask

   // raster tracker, mirrors 800 x 525 from reset
   always @(posedge vga_clk)
   begin
      if (!rst_n)
      begin
         pos_x      <= 0;
         pos_line   <= 0;
         frame_cnt  <= 0;
         frame_mode <= mode_80col;
      end
      else if (pos_x == 799)
      begin
         pos_x <= 0;
         if (pos_line == 524)
         begin
            pos_line   <= 0;
            frame_cnt  <= frame_cnt + 1;
            frame_mode <= mode_80col;           // sampled at frame start only
         end
         else
            pos_line <= pos_line + 1;
      end
      else
         pos_x <= pos_x + 1;
   end

   // outputs settle after the rising edge, checked mid-cycle
   always @(negedge vga_clk)
   begin
      if (rst_n)
      begin
         exp_h = pos_x >= 659 && pos_x <= 754;
         exp_v = (pos_line == 489 && pos_x >= 1) || pos_line == 490 ||
                 (pos_line == 491 && pos_x == 0);
         assert (h_sync === exp_h)
         else
         begin
            sync_err++;
            if (sync_err <= 10)
               $display("error h_sync line %0d x %0d: got %h expected %h",
                        pos_line, pos_x, h_sync, exp_h);
         end
         assert (v_sync === exp_v)
         else
         begin
            sync_err++;
            if (sync_err <= 10)
               $display("error v_sync line %0d x %0d: got %h expected %h",
                        pos_line, pos_x, v_sync, exp_v);
         end
         if (check_en)
         begin
            exp_p = expected_pixel(pos_line, pos_x, frame_mode, inv_video);
            assert (pixel === exp_p)
            else
            begin
               pix_err++;
               if (pix_err <= 10)
                  $display("error pixel frame %0d line %0d x %0d: got %h expected %h",
                           frame_cnt, pos_line, pos_x, pixel, exp_p);
            end
         end
      end
   end

   always @(posedge vga_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial
   begin
      rst_n      = 1'b0;
      mode_80col = 1'b0;              // 64x16 first
      inv_video  = 1'b0;
      host_req   = 1'b0;
      host_we    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      repeat (16) @(posedge vga_clk);
      #1;
      rst_n = 1'b1;

      for (int a = 0; a < GLYPH_BYTES; a++)
      begin
         rnd = next_rand(rnd);
         write_byte(12'h800 | 12'(a), rnd[23:16]);
      end
      for (int a = 0; a < TEXT_BYTES; a++)
      begin
         rnd = next_rand(rnd);
         write_byte(12'(a), rnd[23:16]);   // codes 0x80-0xbf show up as blocks
      end
      for (int a = 0; a < GLYPH_BYTES; a++)
         read_check(12'h800 | 12'(a));
      for (int a = 0; a < TEXT_BYTES; a++)
         read_check(12'(a));

      // lines drawn during loading saw half-filled rams
      wait_line(0, pos_line + 1);
      check_en = 1'b1;
      wait_line(0, 481);              // vertical blanking
      inv_video = 1'b1;
      wait_line(1, 240);
      mode_80col = 1'b1;              // mid-frame, must wait for frame 2
      wait_line(1, 481);
      inv_video = 1'b0;
      wait_line(3, 0);
      check_en = 1'b0;

      total_err = host_err + sync_err + pix_err + i_trs_video_top.i_tb_trs_video_assert.fail_cnt;
      $display("errors: host %0d, sync %0d, pixel %0d, assertion %0d", host_err, sync_err,
               pix_err, i_trs_video_top.i_tb_trs_video_assert.fail_cnt);
      if (total_err == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== trs_video.f ====
hw/trs_video_pkg.sv
hw/video_timing.sv
hw/host_bus_port.sv
hw/text_fetch.sv
hw/glyph_render.sv
hw/trs_video_top.sv
tb/tb_trs_video_assert.sv
tb/tb_trs_video.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f trs_video.f --top-module tb_trs_video -o sim_trs_video

# let the run reach its own summary after an assertion error
out=$(./obj_dir/sim_trs_video +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
